//--- files.f
src/emesh_pkg.sv
src/emesh_split.sv
src/emesh_rr_arb.sv
src/emesh_merge.sv
src/emesh_if.sv
sim/emesh_if_assert.sv
sim/emesh_if_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the emesh interface testbench with Verilator

rm -rf obj_dir sim.log build.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f files.f --top-module emesh_if_tb -o Vemesh_if_tb > build.log 2>&1 ||
   { cat build.log; echo "Verilator build failed"; exit 1; }

# A run stopped by the simulator itself counts as a failure
./obj_dir/Vemesh_if_tb > sim.log 2>&1 ||
   echo "TESTS FAILED (simulator exited with an error)" >> sim.log

cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

//--- sim/emesh_if_assert.sv
module emesh_if_assert #(
   parameter int n = 1
) (
   input logic                     clk,
   input logic                     arst_n,
   input logic [n-1:0]             out_access,
   input logic [n-1:0]             out_ready,
   input emesh_pkg::emesh_packet_t out_packet,
   input logic [2:0]               one_hot_set
);

   timeunit 1ns;
   timeprecision 1ps;

   // Stalled output keeps its access and its packet
   hold_while_stalled: assert property (
      @(posedge clk) disable iff (!arst_n)
      (|(out_access & ~out_ready)) |=> $stable(out_access) && $stable(out_packet)
   ) else $error("Stalled output dropped access or changed its packet");

   // Tx access pair or rx ready triple
   at_most_one_high: assert property (
      @(posedge clk) disable iff (!arst_n)
      $onehot0(one_hot_set)
   ) else $error("More than one bit of an exclusive set is high");

endmodule

bind emesh_split emesh_if_assert #(.n(2)) split_chk (
   .clk         (emesh_ready_in),
   .arst_n      (arst_n),
   .out_access  ({cmesh_tx_access, rmesh_tx_access}),
   .out_ready   ({cmesh_tx_ready, rmesh_tx_ready}),
   .out_packet  (tx_packet),
   .one_hot_set ({1'b0, cmesh_tx_access, rmesh_tx_access})
);

bind emesh_merge emesh_if_assert #(.n(1)) merge_chk (
   .clk         (emesh_ready_in),
   .arst_n      (arst_n),
   .out_access  (emesh_rx_access),
   .out_ready   (emesh_rx_ready),
   .out_packet  (emesh_rx_packet),
   .one_hot_set ({cmesh_rx_ready, rmesh_rx_ready, xmesh_rx_ready})
);

//--- sim/emesh_if_tb.sv
module emesh_if_tb;

   timeunit 1ns;
   timeprecision 1ps;

   //##################################################
   // Test lengths and watchdog
   //##################################################

   localparam int clk_period = 40;
   localparam int n_route    = 32;
   localparam int n_tx_stall = 48;
   localparam int n_single   = 12;
   localparam int n_rr       = 24;
   localparam int n_rx_stall = 24;

   // Stalled runs are given four cycles per packet
   localparam int test_cycles = 40 + n_route + 4*n_tx_stall + 3*2*n_single
                                + 3*n_rr + 2*n_rr + 4*3*n_rx_stall;
   localparam int margin      = 4;
   localparam int watchdog_ns = test_cycles * clk_period * margin;

   logic                     emesh_ready_in;
   logic                     arst_n;
   logic                     emesh_tx_access;
   emesh_pkg::emesh_packet_t emesh_tx_packet;
   logic                     emesh_tx_ready;
   logic                     cmesh_tx_access;
   logic                     rmesh_tx_access;
   emesh_pkg::emesh_packet_t tx_packet;
   logic                     cmesh_tx_ready;
   logic                     rmesh_tx_ready;
   logic                     cmesh_rx_access;
   emesh_pkg::emesh_packet_t cmesh_rx_packet;
   logic                     cmesh_rx_ready;
   logic                     rmesh_rx_access;
   emesh_pkg::emesh_packet_t rmesh_rx_packet;
   logic                     rmesh_rx_ready;
   logic                     xmesh_rx_access;
   emesh_pkg::emesh_packet_t xmesh_rx_packet;
   logic                     xmesh_rx_ready;
   logic                     emesh_rx_access;
   emesh_pkg::emesh_packet_t emesh_rx_packet;
   logic                     emesh_rx_ready;

   // Scoreboard, tx index is the routing bit so 1 means cmesh
   emesh_pkg::emesh_packet_t tx_exp[2][$];
   emesh_pkg::emesh_packet_t rx_exp[3][$];

   int                       errors      = 0;
   logic                     after_reset = 1'b0;
   logic                     tx_stall    = 1'b0;
   logic                     rx_stall    = 1'b0;
   logic                     rr_on       = 1'b0;
   logic                     rr_known    = 1'b0;
   logic [2:0]               rr_mask     = 3'b111;
   emesh_pkg::mesh_src_t     rr_expect   = emesh_pkg::src_cmesh;

   emesh_if dut0 (.*);

   initial begin
      emesh_ready_in = 1'b0;
      forever #(clk_period/2) emesh_ready_in = ~emesh_ready_in;
   end

   //##################################################
   // Compare tasks
   //##################################################

   task automatic check_packet(input emesh_pkg::emesh_packet_t got,
                               input emesh_pkg::emesh_packet_t exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0d ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_src(input emesh_pkg::mesh_src_t got,
                            input emesh_pkg::mesh_src_t exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0d ns: %s got %s expected %s", $time, what, got.name(),
                  exp.name());
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0d ns: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   //##################################################
   // Packet sources and helpers
   //##################################################

   function automatic emesh_pkg::emesh_packet_t random_packet();
      logic [127:0] raw;
      raw = {$urandom, $urandom, $urandom, $urandom};
      return raw[emesh_pkg::pw-1:0];
   endfunction

   // Bits 2:1 carry the source so the merged stream can be sorted again
   function automatic emesh_pkg::emesh_packet_t tagged_packet(input emesh_pkg::mesh_src_t src);
      emesh_pkg::emesh_packet_t pkt;
      pkt = random_packet();
      pkt[2:1] = src;
      return pkt;
   endfunction

   // Next source in the set after cur, order cmesh rmesh xmesh
   function automatic emesh_pkg::mesh_src_t next_active(input emesh_pkg::mesh_src_t cur,
                                                        input logic [2:0] mask);
      emesh_pkg::mesh_src_t s;
      s = cur;
      for (int i = 0; i < 3; i++) begin
         case (s)
            emesh_pkg::src_cmesh: s = emesh_pkg::src_rmesh;
            emesh_pkg::src_rmesh: s = emesh_pkg::src_xmesh;
            default:              s = emesh_pkg::src_cmesh;
         endcase
         if (mask[s]) begin
            return s;
         end
      end
      return cur;
   endfunction

   function automatic logic rx_ready_of(input emesh_pkg::mesh_src_t src);
      case (src)
         emesh_pkg::src_cmesh: return cmesh_rx_ready;
         emesh_pkg::src_rmesh: return rmesh_rx_ready;
         default:              return xmesh_rx_ready;
      endcase
   endfunction

   task automatic drive_rx(input emesh_pkg::mesh_src_t src, input logic acc,
                           input emesh_pkg::emesh_packet_t pkt);
      case (src)
         emesh_pkg::src_cmesh: begin
            cmesh_rx_access <= acc;
            cmesh_rx_packet <= pkt;
         end
         emesh_pkg::src_rmesh: begin
            rmesh_rx_access <= acc;
            rmesh_rx_packet <= pkt;
         end
         default: begin
            xmesh_rx_access <= acc;
            xmesh_rx_packet <= pkt;
         end
      endcase
   endtask

   // Offers n packets back to back, each held until it is taken
   task automatic rx_source(input emesh_pkg::mesh_src_t src, input int n);
      emesh_pkg::emesh_packet_t pkt;
      for (int i = 0; i < n; i++) begin
         pkt = tagged_packet(src);
         rx_exp[src].push_back(pkt);
         drive_rx(src, 1'b1, pkt);
         @(posedge emesh_ready_in);
         while (!rx_ready_of(src)) @(posedge emesh_ready_in);
      end
      drive_rx(src, 1'b0, '0);
   endtask

   task automatic send_tx(input int n);
      emesh_pkg::emesh_packet_t pkt;
      for (int i = 0; i < n; i++) begin
         pkt = random_packet();
         tx_exp[pkt[emesh_pkg::route_bit]].push_back(pkt);
         emesh_tx_access <= 1'b1;
         emesh_tx_packet <= pkt;
         @(posedge emesh_ready_in);
         while (!emesh_tx_ready) @(posedge emesh_ready_in);
      end
      emesh_tx_access <= 1'b0;
   endtask

   task automatic wait_drain();
      while (tx_exp[0].size() + tx_exp[1].size() + rx_exp[0].size()
             + rx_exp[1].size() + rx_exp[2].size() != 0) begin
         @(posedge emesh_ready_in);
      end
   endtask

   task automatic apply_reset();
      arst_n <= 1'b0;
      repeat (3) @(posedge emesh_ready_in);
      arst_n <= 1'b1;
      @(posedge emesh_ready_in);
   endtask

   // Random back-pressure while a stall flag is set
   task automatic drive_readies();
      cmesh_tx_ready <= tx_stall ? (($urandom % 2) != 0) : 1'b1;
      rmesh_tx_ready <= tx_stall ? (($urandom % 2) != 0) : 1'b1;
      emesh_rx_ready <= rx_stall ? (($urandom % 2) != 0) : 1'b1;
   endtask

   //##################################################
   // Output monitor, sampled at the rising edge
   //##################################################

   task automatic pop_tx(input int idx, input string name);
      if (tx_exp[idx].size() == 0) begin
         errors++;
         $display("Packet on the %s tx port at %0d ns while none was expected", name, $time);
      end else begin
         check_packet(tx_packet, tx_exp[idx].pop_front(), {name, " tx packet"});
      end
   endtask

   task automatic watch_outputs();
      emesh_pkg::mesh_src_t got_src;
      if (!arst_n || after_reset) begin
         check_bit(cmesh_tx_access, 1'b0, "cmesh_tx_access at reset");
         check_bit(rmesh_tx_access, 1'b0, "rmesh_tx_access at reset");
         check_bit(emesh_rx_access, 1'b0, "emesh_rx_access at reset");
      end
      after_reset = !arst_n;
      if (!arst_n) begin
         return;
      end
      // Ready only when the slot is empty or its target takes the packet
      check_bit(emesh_tx_ready,
                !(cmesh_tx_access && !cmesh_tx_ready) && !(rmesh_tx_access && !rmesh_tx_ready),
                "emesh_tx_ready");
      if (cmesh_tx_access && cmesh_tx_ready) begin
         pop_tx(1, "cmesh");
      end
      if (rmesh_tx_access && rmesh_tx_ready) begin
         pop_tx(0, "rmesh");
      end
      if (emesh_rx_access && emesh_rx_ready) begin
         got_src = emesh_pkg::mesh_src_t'(emesh_rx_packet[2:1]);
         if (emesh_rx_packet[2:1] == 2'b11 || rx_exp[got_src].size() == 0) begin
            errors++;
            $display("Unexpected packet on emesh rx at %0d ns", $time);
         end else begin
            check_packet(emesh_rx_packet, rx_exp[got_src].pop_front(), "emesh rx packet");
         end
         if (rr_on) begin
            if (rr_known) begin
               check_src(got_src, rr_expect, "round-robin source");
            end
            rr_expect = next_active(got_src, rr_mask);
            rr_known  = 1'b1;
         end
      end
   endtask

   //##################################################
   // Directed tests
   //##################################################

   task automatic reset_values();
      apply_reset();
      repeat (2) @(posedge emesh_ready_in);
   endtask

   task automatic route_packets();
      send_tx(n_route);
      wait_drain();
   endtask

   task automatic stall_tx_side();
      tx_stall = 1'b1;
      send_tx(n_tx_stall);
      wait_drain();
      tx_stall = 1'b0;
   endtask

   task automatic merge_single_source();
      rx_source(emesh_pkg::src_cmesh, n_single);
      wait_drain();
      rx_source(emesh_pkg::src_rmesh, n_single);
      wait_drain();
      rx_source(emesh_pkg::src_xmesh, n_single);
      wait_drain();
   endtask

   task automatic round_robin_order();
      // Pointer starts at cmesh only after a reset
      apply_reset();
      rr_mask   = 3'b111;
      rr_expect = emesh_pkg::src_cmesh;
      rr_known  = 1'b1;
      rr_on     = 1'b1;
      fork
         rx_source(emesh_pkg::src_cmesh, n_rr);
         rx_source(emesh_pkg::src_rmesh, n_rr);
         rx_source(emesh_pkg::src_xmesh, n_rr);
      join
      wait_drain();
      // Two sources alternate
      rr_mask  = 3'b101;
      rr_known = 1'b0;
      fork
         rx_source(emesh_pkg::src_cmesh, n_rr);
         rx_source(emesh_pkg::src_xmesh, n_rr);
      join
      wait_drain();
      rr_on = 1'b0;
   endtask

   task automatic stall_rx_side();
      rx_stall = 1'b1;
      fork
         rx_source(emesh_pkg::src_cmesh, n_rx_stall);
         rx_source(emesh_pkg::src_rmesh, n_rx_stall);
         rx_source(emesh_pkg::src_xmesh, n_rx_stall);
      join
      wait_drain();
      rx_stall = 1'b0;
   endtask

   initial begin
      void'($urandom(75408));
      arst_n          <= 1'b0;
      emesh_tx_access <= 1'b0;
      emesh_tx_packet <= '0;
      cmesh_tx_ready  <= 1'b1;
      rmesh_tx_ready  <= 1'b1;
      cmesh_rx_access <= 1'b0;
      cmesh_rx_packet <= '0;
      rmesh_rx_access <= 1'b0;
      rmesh_rx_packet <= '0;
      xmesh_rx_access <= 1'b0;
      xmesh_rx_packet <= '0;
      emesh_rx_ready  <= 1'b1;
      fork
         forever begin
            @(posedge emesh_ready_in);
            watch_outputs();
         end
         forever begin
            @(posedge emesh_ready_in);
            drive_readies();
         end
      join_none
      reset_values();
      route_packets();
      stall_tx_side();
      merge_single_source();
      round_robin_order();
      stall_rx_side();
      repeat (4) @(posedge emesh_ready_in);
      $display("All tests run, %0d errors", errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #watchdog_ns;
      $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

//--- src/emesh_if.sv
module emesh_if (
   input  logic                     emesh_ready_in,
   input  logic                     arst_n,

   //##################################################
   // Emesh to cmesh or rmesh
   //##################################################
   input  logic                     emesh_tx_access,
   input  emesh_pkg::emesh_packet_t emesh_tx_packet,
   output logic                     emesh_tx_ready,
   output logic                     cmesh_tx_access,
   output logic                     rmesh_tx_access,
   output emesh_pkg::emesh_packet_t tx_packet,
   input  logic                     cmesh_tx_ready,
   input  logic                     rmesh_tx_ready,

   //##################################################
   // Cmesh, rmesh and xmesh to emesh
   //##################################################
   input  logic                     cmesh_rx_access,
   input  emesh_pkg::emesh_packet_t cmesh_rx_packet,
   output logic                     cmesh_rx_ready,
   input  logic                     rmesh_rx_access,
   input  emesh_pkg::emesh_packet_t rmesh_rx_packet,
   output logic                     rmesh_rx_ready,
   input  logic                     xmesh_rx_access,
   input  emesh_pkg::emesh_packet_t xmesh_rx_packet,
   output logic                     xmesh_rx_ready,
   output logic                     emesh_rx_access,
   output emesh_pkg::emesh_packet_t emesh_rx_packet,
   input  logic                     emesh_rx_ready
);

   // Arbiter to merge
   logic [emesh_pkg::num_src-1:0] grant;
   emesh_pkg::mesh_src_t          grant_src;
   logic                          take;

   // Outgoing direction, one registered stage
   emesh_split split0 (
      .emesh_ready_in  (emesh_ready_in),
      .arst_n          (arst_n),
      .emesh_tx_access (emesh_tx_access),
      .emesh_tx_packet (emesh_tx_packet),
      .emesh_tx_ready  (emesh_tx_ready),
      .cmesh_tx_access (cmesh_tx_access),
      .rmesh_tx_access (rmesh_tx_access),
      .tx_packet       (tx_packet),
      .cmesh_tx_ready  (cmesh_tx_ready),
      .rmesh_tx_ready  (rmesh_tx_ready)
   );

   // Round-robin over the inbound access bits
   emesh_rr_arb arb0 (
      .emesh_ready_in (emesh_ready_in),
      .arst_n         (arst_n),
      .cmesh_req      (cmesh_rx_access),
      .rmesh_req      (rmesh_rx_access),
      .xmesh_req      (xmesh_rx_access),
      .take           (take),
      .grant          (grant),
      .grant_src      (grant_src)
   );

   // Incoming direction, one registered stage
   emesh_merge merge0 (
      .emesh_ready_in  (emesh_ready_in),
      .arst_n          (arst_n),
      .cmesh_rx_access (cmesh_rx_access),
      .cmesh_rx_packet (cmesh_rx_packet),
      .rmesh_rx_access (rmesh_rx_access),
      .rmesh_rx_packet (rmesh_rx_packet),
      .xmesh_rx_access (xmesh_rx_access),
      .xmesh_rx_packet (xmesh_rx_packet),
      .cmesh_rx_ready  (cmesh_rx_ready),
      .rmesh_rx_ready  (rmesh_rx_ready),
      .xmesh_rx_ready  (xmesh_rx_ready),
      .grant           (grant),
      .grant_src       (grant_src),
      .take            (take),
      .emesh_rx_access (emesh_rx_access),
      .emesh_rx_packet (emesh_rx_packet),
      .emesh_rx_ready  (emesh_rx_ready)
   );

endmodule

//--- src/emesh_merge.sv
module emesh_merge (
   input  logic                          emesh_ready_in,
   input  logic                          arst_n,

   // Inbound meshes
   input  logic                          cmesh_rx_access,
   input  emesh_pkg::emesh_packet_t      cmesh_rx_packet,
   input  logic                          rmesh_rx_access,
   input  emesh_pkg::emesh_packet_t      rmesh_rx_packet,
   input  logic                          xmesh_rx_access,
   input  emesh_pkg::emesh_packet_t      xmesh_rx_packet,
   output logic                          cmesh_rx_ready,
   output logic                          rmesh_rx_ready,
   output logic                          xmesh_rx_ready,

   // Arbiter
   input  logic [emesh_pkg::num_src-1:0] grant,
   input  emesh_pkg::mesh_src_t          grant_src,
   output logic                          take,

   // To the local endpoint
   output logic                          emesh_rx_access,
   output emesh_pkg::emesh_packet_t      emesh_rx_packet,
   input  logic                          emesh_rx_ready
);

   logic                          slot_valid;
   emesh_pkg::emesh_packet_t      slot_packet;
   emesh_pkg::emesh_packet_t      sel_packet;
   logic                          load_en;
   logic                          accept;
   logic [emesh_pkg::num_src-1:0] rx_access;
   logic [emesh_pkg::num_src-1:0] rx_ready;

   //##################################################
   // Load enable and source readies
   //##################################################

   // Empty slot or the endpoint drains it this cycle
   assign load_en = ~slot_valid | emesh_rx_ready;
   assign take    = load_en;

   assign rx_access = {xmesh_rx_access, rmesh_rx_access, cmesh_rx_access};

   // Ungranted sources wait
   assign rx_ready = grant & {emesh_pkg::num_src{load_en}};

   assign cmesh_rx_ready = rx_ready[emesh_pkg::src_cmesh];
   assign rmesh_rx_ready = rx_ready[emesh_pkg::src_rmesh];
   assign xmesh_rx_ready = rx_ready[emesh_pkg::src_xmesh];

   // A transfer on any inbound link fills the slot
   assign accept = |(rx_ready & rx_access);

   //##################################################
   // Packet select and output slot
   //##################################################

   always_comb begin
      case (grant_src)
         emesh_pkg::src_cmesh: sel_packet = cmesh_rx_packet;
         emesh_pkg::src_rmesh: sel_packet = rmesh_rx_packet;
         default:              sel_packet = xmesh_rx_packet;
      endcase
   end

   always_ff @(posedge emesh_ready_in or negedge arst_n) begin
      if (!arst_n) begin
         slot_valid <= 1'b0;
      end else if (load_en) begin
         slot_valid <= accept;
      end
   end

   // Payload
   always_ff @(posedge emesh_ready_in) begin
      if (accept) begin
         slot_packet <= sel_packet;
      end
   end

   assign emesh_rx_access = slot_valid;
   assign emesh_rx_packet = slot_packet;

endmodule

//--- src/emesh_pkg.sv
package emesh_pkg;

   //##################################################
   // Widths
   //##################################################

   // Address width of the mesh fabric
   localparam int aw = 32;

   // Packet carries two addresses plus control and data fields
   localparam int pw = 2*aw + 40;

   // Number of inbound meshes merged onto the emesh
   localparam int num_src = 3;

   // Position of the bit that selects the outgoing network
   localparam int route_bit = 0;

   //##################################################
   // Types
   //##################################################

   // One whole packet, only the routing bit is interpreted
   typedef logic [pw-1:0] emesh_packet_t;

   // Inbound sources in round-robin order
   // Also used as the grant code from the arbiter to the merge
   typedef enum logic [1:0] {
      src_cmesh = 2'd0,
      src_rmesh = 2'd1,
      src_xmesh = 2'd2
   } mesh_src_t;

endpackage

//--- src/emesh_rr_arb.sv
module emesh_rr_arb (
   input  logic                          emesh_ready_in,
   input  logic                          arst_n,

   // Requests from the inbound meshes
   input  logic                          cmesh_req,
   input  logic                          rmesh_req,
   input  logic                          xmesh_req,

   // Merge stage takes the granted packet
   input  logic                          take,

   output logic [emesh_pkg::num_src-1:0] grant,
   output emesh_pkg::mesh_src_t          grant_src
);

   //##################################################
   // Cyclic order cmesh, rmesh, xmesh
   //##################################################

   function automatic emesh_pkg::mesh_src_t next_src(input emesh_pkg::mesh_src_t src);
      case (src)
         emesh_pkg::src_cmesh: return emesh_pkg::src_rmesh;
         emesh_pkg::src_rmesh: return emesh_pkg::src_xmesh;
         default:              return emesh_pkg::src_cmesh;
      endcase
   endfunction

   emesh_pkg::mesh_src_t         ptr;
   emesh_pkg::mesh_src_t         cand1;
   emesh_pkg::mesh_src_t         cand2;
   logic [emesh_pkg::num_src-1:0] req;
   logic                         any_req;

   assign req     = {xmesh_req, rmesh_req, cmesh_req};
   assign any_req = |req;

   // Candidates after the pointer, in order
   assign cand1 = next_src(ptr);
   assign cand2 = next_src(cand1);

   //##################################################
   // Grant
   //##################################################

   // First active request at or after the pointer
   always_comb begin
      if (req[ptr]) begin
         grant_src = ptr;
      end else if (req[cand1]) begin
         grant_src = cand1;
      end else begin
         grant_src = cand2;
      end
   end

   // No grant at all when nothing is requested
   always_comb begin
      grant = '0;
      if (any_req) begin
         grant[grant_src] = 1'b1;
      end
   end

   // Pointer moves past the winner only when the grant is used
   always_ff @(posedge emesh_ready_in or negedge arst_n) begin
      if (!arst_n) begin
         ptr <= emesh_pkg::src_cmesh;
      end else if (take && any_req) begin
         ptr <= next_src(grant_src);
      end
   end

endmodule

//--- src/emesh_split.sv
module emesh_split (
   input  logic                     emesh_ready_in,
   input  logic                     arst_n,

   // From the local endpoint
   input  logic                     emesh_tx_access,
   input  emesh_pkg::emesh_packet_t emesh_tx_packet,
   output logic                     emesh_tx_ready,

   // To the cmesh and the rmesh
   output logic                     cmesh_tx_access,
   output logic                     rmesh_tx_access,
   output emesh_pkg::emesh_packet_t tx_packet,
   input  logic                     cmesh_tx_ready,
   input  logic                     rmesh_tx_ready
);

   //##################################################
   // Output slot
   //##################################################

   logic                     slot_valid;
   logic                     slot_to_cmesh;
   emesh_pkg::emesh_packet_t slot_packet;
   logic                     target_ready;
   logic                     load_en;
   logic                     accept;

   // Only the network the held packet goes to can drain the slot
   assign target_ready = slot_to_cmesh ? cmesh_tx_ready : rmesh_tx_ready;

   // Slot takes a new packet when empty or leaving this cycle
   assign load_en = ~slot_valid | target_ready;

   assign accept = load_en & emesh_tx_access;

   always_ff @(posedge emesh_ready_in or negedge arst_n) begin
      if (!arst_n) begin
         slot_valid    <= 1'b0;
         slot_to_cmesh <= 1'b0;
      end else if (load_en) begin
         slot_valid <= emesh_tx_access;
         // Target latched with the packet, routing bit set means cmesh
         if (emesh_tx_access) begin
            slot_to_cmesh <= emesh_tx_packet[emesh_pkg::route_bit];
         end
      end
   end

   // Payload
   always_ff @(posedge emesh_ready_in) begin
      if (accept) begin
         slot_packet <= emesh_tx_packet;
      end
   end

   //##################################################
   // Outputs
   //##################################################

   // Upstream sees back-pressure only from the held packet's target
   assign emesh_tx_ready = load_en;

   assign cmesh_tx_access = slot_valid & slot_to_cmesh;
   assign rmesh_tx_access = slot_valid & ~slot_to_cmesh;

   // Shared by both networks, the access bit picks the taker
   assign tx_packet = slot_packet;

endmodule
